// File: Bender.yml
package:
  name: mips_core

sources:
  - logic/mips_pkg.sv
  - logic/ctrl_if.sv
  - logic/mem_if.sv
  - logic/control_fsm.sv
  - logic/alu.sv
  - logic/reg_file.sv
  - logic/apb_mem_port.sv
  - logic/datapath.sv
  - logic/mips_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mips_core.sv

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_SLT: result = XLEN'($signed(a) < $signed(b));
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: logic/apb_mem_port.sv
`timescale 1ns/1ps

module apb_mem_port import mips_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    mem_if.port             mem,
    output logic [XLEN-1:0] paddr,
    output logic [XLEN-1:0] pwdata,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    input  logic [XLEN-1:0] prdata,
    input  logic            pready
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } phase_e;

    phase_e phase;

    assign psel    = (phase != IDLE);
    assign penable = (phase == ACCESS);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= IDLE;
            pwrite   <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            case (phase)
                IDLE: begin
                    if (mem.req) begin
                        phase  <= SETUP;
                        pwrite <= mem.write;
                    end
                end
                SETUP: phase <= ACCESS;
                ACCESS: begin
                    if (pready) begin      // Wait states hold here
                        phase    <= IDLE;
                        mem.done <= 1'b1;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == IDLE && mem.req) begin
            paddr  <= mem.addr;
            pwdata <= mem.wdata;
        end
        if (phase == ACCESS && pready)
            mem.rdata <= prdata;
    end

endmodule

// File: logic/control_fsm.sv
`timescale 1ns/1ps

module control_fsm import mips_pkg::*; (
    input logic  clk,
    input logic  reset,
    ctrl_if.ctrl ctrl,
    mem_if.ctrl  mem
);

    state_e  state;
    state_e  next_state;
    logic    mem_wait;     // High from request until done
    logic    mem_state;
    logic    funct_ok;
    alu_op_e r_alu_op;

    assign mem_state = (state == FETCH) || (state == MEM_READ) || (state == MEM_WRITE);
    assign mem.req   = mem_state && !mem_wait;
    assign mem.write = (state == MEM_WRITE);

    assign funct_ok = ctrl.funct inside {FN_ADD, FN_SUB, FN_AND, FN_SLT};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= RESET;
            mem_wait <= 1'b0;
        end else begin
            state <= next_state;
            if (mem.done)
                mem_wait <= 1'b0;
            else if (mem.req)
                mem_wait <= 1'b1;
        end
    end

    always_comb begin
        case (ctrl.funct)
            FN_SUB:  r_alu_op = ALU_SUB;
            FN_AND:  r_alu_op = ALU_AND;
            FN_SLT:  r_alu_op = ALU_SLT;
            default: r_alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET:  next_state = FETCH;
            FETCH:  if (mem.done) next_state = DECODE;
            DECODE: begin
                case (ctrl.opcode)
                    OP_RTYPE:     next_state = funct_ok ? EXEC_R : FETCH;
                    OP_ADDI:      next_state = EXEC_I;
                    OP_LW, OP_SW: next_state = MEM_ADDR;
                    OP_BEQ, OP_BNE: next_state = BRANCH;
                    OP_J:         next_state = JUMP;
                    default:      next_state = FETCH;  // Unsupported opcode runs as no-op
                endcase
            end
            EXEC_R, EXEC_I: next_state = WB_ALU;
            MEM_ADDR:  next_state = (ctrl.opcode == OP_LW) ? MEM_READ : MEM_WRITE;
            MEM_READ:  if (mem.done) next_state = WB_MEM;
            MEM_WRITE: if (mem.done) next_state = FETCH;
            default:   next_state = FETCH;
        endcase
    end

    always_comb begin
        ctrl.pc_write      = 1'b0;
        ctrl.pc_write_cond = 1'b0;
        ctrl.branch_ne     = 1'b0;
        ctrl.ir_load       = 1'b0;
        ctrl.ab_load       = 1'b0;
        ctrl.alu_op        = ALU_ADD;
        ctrl.alu_src_a     = 1'b0;
        ctrl.alu_src_b     = SRCB_REG;
        ctrl.alu_out_load  = 1'b0;
        ctrl.mdr_load      = 1'b0;
        ctrl.reg_write     = 1'b0;
        ctrl.reg_dst       = 1'b0;
        ctrl.mem_to_reg    = 1'b0;
        ctrl.pc_source     = PCSRC_ALU;
        ctrl.iord          = 1'b0;
        case (state)
            FETCH: begin
                ctrl.ir_load   = mem.done;
                ctrl.mdr_load  = mem.done;
                ctrl.pc_write  = mem.done;   // PC + 4
                ctrl.alu_src_b = SRCB_FOUR;
            end
            DECODE: begin
                ctrl.ab_load      = 1'b1;
                ctrl.alu_src_b    = SRCB_BRANCH;
                ctrl.alu_out_load = 1'b1;
            end
            EXEC_R: begin
                ctrl.alu_src_a    = 1'b1;
                ctrl.alu_op       = r_alu_op;
                ctrl.alu_out_load = 1'b1;
            end
            EXEC_I, MEM_ADDR: begin
                ctrl.alu_src_a    = 1'b1;
                ctrl.alu_src_b    = SRCB_IMM;
                ctrl.alu_out_load = 1'b1;
            end
            MEM_READ: begin
                ctrl.iord     = 1'b1;
                ctrl.mdr_load = mem.done;
            end
            MEM_WRITE: ctrl.iord = 1'b1;
            WB_ALU: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = (ctrl.opcode == OP_RTYPE);
            end
            WB_MEM: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            BRANCH: begin
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_op        = ALU_SUB;
                ctrl.pc_write_cond = 1'b1;
                ctrl.branch_ne     = (ctrl.opcode == OP_BNE);
                ctrl.pc_source     = PCSRC_ALUOUT;
            end
            JUMP: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PCSRC_JUMP;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if import mips_pkg::*; ();

    logic       pc_write;
    logic       pc_write_cond;
    logic       branch_ne;
    logic       ir_load;
    logic       ab_load;
    alu_op_e    alu_op;
    logic       alu_src_a;     // 0 selects PC, 1 selects A
    logic [1:0] alu_src_b;
    logic       alu_out_load;
    logic       mdr_load;
    logic       reg_write;
    logic       reg_dst;       // 1 writes rd, 0 writes rt
    logic       mem_to_reg;
    logic [1:0] pc_source;
    logic       iord;          // Memory address from ALU-out

    opcode_e    opcode;
    funct_e     funct;
    logic       alu_zero;

    modport ctrl (
        output pc_write, pc_write_cond, branch_ne, ir_load, ab_load, alu_op,
               alu_src_a, alu_src_b, alu_out_load, mdr_load, reg_write,
               reg_dst, mem_to_reg, pc_source, iord,
        input  opcode, funct, alu_zero
    );

    modport dp (
        input  pc_write, pc_write_cond, branch_ne, ir_load, ab_load, alu_op,
               alu_src_a, alu_src_b, alu_out_load, mdr_load, reg_write,
               reg_dst, mem_to_reg, pc_source, iord,
        output opcode, funct, alu_zero
    );

endinterface

// File: logic/datapath.sv
`timescale 1ns/1ps

module datapath import mips_pkg::*; (
    input logic clk,
    input logic reset,
    ctrl_if.dp  ctrl,
    mem_if.dp   mem
);

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       ir;
    logic [XLEN-1:0]       a_q;
    logic [XLEN-1:0]       b_q;
    logic [XLEN-1:0]       alu_out;
    logic [XLEN-1:0]       mdr;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    logic [XLEN-1:0]       src_a;
    logic [XLEN-1:0]       src_b;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       imm_ext;
    logic [XLEN-1:0]       jump_target;
    logic [XLEN-1:0]       pc_next;
    logic [XLEN-1:0]       wb_data;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  pc_en;

    assign ctrl.opcode = opcode_e'(ir[31:26]);
    assign ctrl.funct  = funct_e'(ir[5:0]);

    assign imm_ext     = {{(XLEN-16){ir[15]}}, ir[15:0]};
    assign jump_target = {pc[XLEN-1:XLEN-4], ir[25:0], 2'b00};

    assign mem.addr  = ctrl.iord ? alu_out : pc;
    assign mem.wdata = b_q;

    assign src_a = ctrl.alu_src_a ? a_q : pc;

    always_comb begin
        case (ctrl.alu_src_b)
            SRCB_REG:    src_b = b_q;
            SRCB_FOUR:   src_b = XLEN'(4);
            SRCB_IMM:    src_b = imm_ext;
            SRCB_BRANCH: src_b = imm_ext << 2;   // Word offset
        endcase
    end

    always_comb begin
        case (ctrl.pc_source)
            PCSRC_ALUOUT: pc_next = alu_out;
            PCSRC_JUMP:   pc_next = jump_target;
            default:      pc_next = alu_result;
        endcase
    end

    // beq takes on zero, bne on nonzero
    assign pc_en = ctrl.pc_write || (ctrl.pc_write_cond && (ctrl.alu_zero != ctrl.branch_ne));

    assign waddr   = ctrl.reg_dst ? ir[15:11] : ir[20:16];
    assign wb_data = ctrl.mem_to_reg ? mdr : alu_out;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= RESET_PC;
        else if (pc_en)
            pc <= pc_next;
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_load)
            ir <= mem.rdata;
        if (ctrl.mdr_load)
            mdr <= mem.rdata;
        if (ctrl.ab_load) begin
            a_q <= rdata1;
            b_q <= rdata2;
        end
        if (ctrl.alu_out_load)
            alu_out <= alu_result;
    end

    reg_file rf_i (
        .clk    (clk),
        .raddr1 (ir[25:21]),
        .raddr2 (ir[20:16]),
        .waddr  (waddr),
        .we     (ctrl.reg_write),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu alu_i (
        .a      (src_a),
        .b      (src_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (ctrl.alu_zero)
    );

endmodule

// File: logic/mem_if.sv
`timescale 1ns/1ps

interface mem_if import mips_pkg::*; ();

    logic            req;     // One-cycle pulse per access
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    logic            done;    // Ends the access

    modport ctrl (output req, write, input done);

    modport dp (output addr, wdata, input rdata);

    modport port (input req, write, addr, wdata, output rdata, done);

endinterface

// File: logic/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    output logic [XLEN-1:0] paddr,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output logic [XLEN-1:0] pwdata,
    input  logic [XLEN-1:0] prdata,
    input  logic            pready
);

    ctrl_if ctrl_bus ();
    mem_if  mem_bus ();

    control_fsm ctrl_i (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.ctrl),
        .mem   (mem_bus.ctrl)
    );

    datapath dp_i (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.dp),
        .mem   (mem_bus.dp)
    );

    apb_mem_port apb_i (
        .clk     (clk),
        .reset   (reset),
        .mem     (mem_bus.port),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_SLT = 6'h2A
    } funct_e;

    typedef enum logic [3:0] {
        RESET,
        FETCH,
        DECODE,
        EXEC_R,
        EXEC_I,
        MEM_ADDR,
        MEM_READ,
        MEM_WRITE,
        WB_ALU,
        WB_MEM,
        BRANCH,
        JUMP
    } state_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_SLT
    } alu_op_e;

    // ALU B input
    localparam logic [1:0] SRCB_REG    = 2'd0;
    localparam logic [1:0] SRCB_FOUR   = 2'd1;
    localparam logic [1:0] SRCB_IMM    = 2'd2;
    localparam logic [1:0] SRCB_BRANCH = 2'd3;

    // Next PC source
    localparam logic [1:0] PCSRC_ALU    = 2'd0;
    localparam logic [1:0] PCSRC_ALUOUT = 2'd1;
    localparam logic [1:0] PCSRC_JUMP   = 2'd2;

endpackage

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic                  we,
    input  logic [XLEN-1:0]       wdata,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    // $zero reads as constant
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: sim/tb_model.svh
localparam int NUM_INSTR  = 150;
localparam int HALT_IDX   = NUM_INSTR;   // j to itself after the random part
localparam int DATA_BASE  = 'h400;
localparam int DATA_WORDS = 16;
localparam int MEM_WORDS  = 512;

logic [XLEN-1:0] mem [MEM_WORDS];        // Shared by program and data region
int unsigned     wait_tab [MEM_WORDS];   // Wait cycles per APB transfer
logic [XLEN-1:0] pc_trace [$];
logic [XLEN-1:0] store_addr_q [$];
logic [XLEN-1:0] store_data_q [$];

function automatic logic [XLEN-1:0] enc_r(input logic [4:0] rs, rt, rd,
                                          input logic [5:0] funct);
    return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [XLEN-1:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [XLEN-1:0] enc_j(input int idx);
    return {OP_J, 26'(idx)};
endfunction

task automatic build_program();
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] daddr;
    int unsigned kind;
    int          off;
    for (int w = 0; w < MEM_WORDS; w++) begin
        mem[w]      = XLEN'(w * 4) ^ 32'hC0DE_0000;
        wait_tab[w] = $urandom % 4;
    end
    for (int k = 0; k < DATA_WORDS; k++)
        mem[DATA_BASE / 4 + k] = $urandom;
    for (int i = 0; i < NUM_INSTR; i++) begin
        rs    = 5'($urandom);
        rt    = 5'($urandom);
        rd    = 5'($urandom);
        daddr = 16'(DATA_BASE + 4 * ($urandom % DATA_WORDS));
        off   = 1 + $urandom % 4;
        if (i + 1 + off > HALT_IDX)
            off = HALT_IDX - i - 1;
        // Prologue gives every register a known value
        if (i < 31) begin
            rs   = '0;
            rt   = 5'(i + 1);
            kind = (i % 2 == 0) ? 4 : 5;
        end else
            kind = $urandom % 10;
        case (kind)
            0: mem[i] = enc_r(rs, rt, rd, FN_ADD);
            1: mem[i] = enc_r(rs, rt, rd, FN_SUB);
            2: mem[i] = enc_r(rs, rt, rd, FN_AND);
            3: mem[i] = enc_r(rs, rt, rd, FN_SLT);
            4: mem[i] = enc_i(OP_ADDI, rs, rt, 16'($urandom));
            5: mem[i] = enc_i(OP_LW, 5'd0, rt, daddr);
            6: mem[i] = enc_i(OP_SW, 5'd0, rt, daddr);
            7: mem[i] = enc_i(OP_BEQ, rs, rt, 16'(off));
            8: mem[i] = enc_i(OP_BNE, rs, rt, 16'(off));
            default: mem[i] = enc_j(i + 1 + off);
        endcase
    end
    mem[HALT_IDX] = enc_j(HALT_IDX);
endtask

// Instruction-level run of the same program
task automatic run_model();
    logic [XLEN-1:0] dmem [MEM_WORDS];
    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] ir;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] next_pc;
    dmem    = mem;
    regs[0] = '0;
    pc      = RESET_PC;
    while (pc != HALT_IDX * 4) begin
        pc_trace.push_back(pc);
        ir      = dmem[pc[10:2]];
        a       = regs[ir[25:21]];
        b       = regs[ir[20:16]];
        imm     = {{16{ir[15]}}, ir[15:0]};
        next_pc = pc + 4;
        case (ir[31:26])
            OP_RTYPE: begin
                case (ir[5:0])
                    FN_ADD:  regs[ir[15:11]] = a + b;
                    FN_SUB:  regs[ir[15:11]] = a - b;
                    FN_AND:  regs[ir[15:11]] = a & b;
                    FN_SLT:  regs[ir[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
                    default: ;
                endcase
            end
            OP_ADDI: regs[ir[20:16]] = a + imm;
            OP_LW:   regs[ir[20:16]] = dmem[(a + imm) >> 2];
            OP_SW: begin
                dmem[(a + imm) >> 2] = b;
                store_addr_q.push_back(a + imm);
                store_data_q.push_back(b);
            end
            OP_BEQ:  if (a == b) next_pc = pc + 4 + (imm << 2);
            OP_BNE:  if (a != b) next_pc = pc + 4 + (imm << 2);
            OP_J:    next_pc = {pc[31:28], ir[25:0], 2'b00};
            default: ;
        endcase
        regs[0] = '0;   // Writes to $zero dropped
        pc      = next_pc;
    end
    pc_trace.push_back(pc);   // Halt address
endtask

// File: sim/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

    logic            clk;
    logic            reset;
    logic [XLEN-1:0] paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [XLEN-1:0] pwdata;
    logic [XLEN-1:0] prdata;
    logic            pready;

    int errors     = 0;
    int cycles     = 0;
    int halt_count = 0;
    int fetch_idx  = 0;
    int store_idx  = 0;

    `include "tb_model.svh"

    // Worst case per instruction is a load with three wait cycles on both transfers
    localparam int TIMEOUT = NUM_INSTR * (5 + 2 * 6) + 100;

    mips_core dut_i (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_eq(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                            input string what);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic note_fetch(input logic [XLEN-1:0] addr);
        if (fetch_idx < pc_trace.size())
            check_eq(addr, pc_trace[fetch_idx], $sformatf("fetch %0d address", fetch_idx));
        else
            check_eq(addr, HALT_IDX * 4, "fetch after halt");
        fetch_idx++;
        if (addr == HALT_IDX * 4)
            halt_count++;
    endtask

    task automatic note_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        if (store_idx < store_addr_q.size()) begin
            check_eq(addr, store_addr_q[store_idx], $sformatf("store %0d address", store_idx));
            check_eq(data, store_data_q[store_idx], $sformatf("store %0d data", store_idx));
        end else begin
            errors++;
            $display("Unexpected APB write of %h to %h at %0t ns", data, addr, $time);
        end
        store_idx++;
    endtask

    // APB memory and protocol monitor sampling at the falling edge
    initial begin : apb_memory
        logic [XLEN-1:0] t_addr;
        logic [XLEN-1:0] t_wdata;
        logic            t_write;
        logic            next_ready;
        bit              in_xfer;
        bit              first_setup;
        int unsigned     waits;
        int unsigned     xfers;
        in_xfer     = 1'b0;
        first_setup = 1'b1;
        next_ready  = 1'b0;
        waits       = 0;
        xfers       = 0;
        forever begin
            @(negedge clk);
            if (reset) begin
                check_eq(psel, 1'b0, "psel during reset");
                check_eq(penable, 1'b0, "penable during reset");
            end else if (!in_xfer) begin
                check_eq(penable, 1'b0, "penable outside a transfer");
                if (psel) begin
                    t_addr  = paddr;
                    t_write = pwrite;
                    t_wdata = pwdata;
                    if (first_setup) begin
                        check_eq(paddr, RESET_PC, "first fetch address");
                        check_eq(pwrite, 1'b0, "first transfer direction");
                        first_setup = 1'b0;
                    end
                    if (!pwrite && paddr < DATA_BASE)
                        note_fetch(paddr);
                    waits      = wait_tab[xfers % MEM_WORDS];
                    xfers++;
                    next_ready = (waits == 0);
                    in_xfer    = 1'b1;
                end
            end else begin
                check_eq(psel, 1'b1, "psel in access phase");
                check_eq(penable, 1'b1, "penable in access phase");
                check_eq(paddr, t_addr, "paddr held through transfer");
                check_eq(pwrite, t_write, "pwrite held through transfer");
                if (t_write)
                    check_eq(pwdata, t_wdata, "pwdata held through transfer");
                if (pready) begin
                    if (t_write) begin
                        note_store(t_addr, t_wdata);
                        mem[t_addr[10:2]] = t_wdata;
                    end
                    next_ready = 1'b0;
                    in_xfer    = 1'b0;
                end else begin
                    waits--;
                    next_ready = (waits == 0);
                end
            end
            @(posedge clk);
            #1;
            pready = next_ready;
            prdata = in_xfer ? mem[t_addr[10:2]] : '0;
        end
    end

    initial begin
        void'($urandom(25));
        reset  = 1'b1;
        pready = 1'b0;
        prdata = '0;
        build_program();
        run_model();
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        while (halt_count < 2 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (halt_count < 2) begin
            errors++;
            $display("Timeout: program did not halt within %0d cycles", TIMEOUT);
        end else
            check_eq(store_idx, store_addr_q.size(), "number of APB writes");
        $display("Errors: %0d, stores checked: %0d", errors, store_idx);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+sim
logic/mips_pkg.sv
logic/ctrl_if.sv
logic/mem_if.sv
logic/control_fsm.sv
logic/alu.sv
logic/reg_file.sv
logic/apb_mem_port.sv
logic/datapath.sv
logic/mips_core.sv
sim/tb_mips_core.sv
